// ==== common/vga_pkg.sv ====
// VGA frame-buffer shared definitions
// Bus width, 640x480 porch and sync widths, line phases, size helpers
`default_nettype none

package vga_pkg;

    // Width of both memory ports
    localparam int word_bits = 32;
    localparam int word_bytes = word_bits / 8;
    // Bits of h_count that select a pixel inside a word
    localparam int pix_sel_bits = $clog2(word_bits);

    // Horizontal blanking in pixels
    localparam int h_front = 16;
    localparam int h_sync = 96;
    localparam int h_back = 48;

    // Vertical blanking in lines
    localparam int v_front = 10;
    localparam int v_sync = 2;
    localparam int v_back = 33;

    // Both syncs pulse low
    localparam logic sync_active = 1'b0;

    // Position of the beam inside a line or a frame
    typedef enum logic [1:0] {
        ph_active,
        ph_front,
        ph_sync,
        ph_back
    } line_phase_e;

    // ======================================
    // Size helpers
    // ======================================
    function automatic int h_total_of(int h_act);
        return h_act + h_front + h_sync + h_back;
    endfunction

    function automatic int v_total_of(int v_act);
        return v_act + v_front + v_sync + v_back;
    endfunction

    function automatic int h_count_bits(int h_act);
        return $clog2(h_total_of(h_act));
    endfunction

    function automatic int v_count_bits(int v_act);
        return $clog2(v_total_of(v_act));
    endfunction

    // Frame size in words, one bit per pixel
    function automatic int fb_words(int h_act, int v_act);
        return (h_act / word_bits) * v_act;
    endfunction

    // One spare bit so that addresses past the frame stay reachable
    function automatic int fb_addr_bits(int h_act, int v_act);
        return $clog2(fb_words(h_act, v_act)) + 1;
    endfunction

endpackage

`default_nettype wire

// ==== common/vga_mem_ifs.sv ====
// Frame-buffer memory port bundles
// Core read/write port and display read port
`timescale 1ns/1ps
`default_nettype none

// CPU side, byte-enabled read/write
interface vga_core_port_if #(parameter int addr_bits = 15);
    import vga_pkg::*;

    logic [addr_bits-1:0]  addr;
    logic [word_bits-1:0]  wdata;
    logic [word_bytes-1:0] be;
    logic                  we;
    logic                  en;
    logic [word_bits-1:0]  rdata;

    modport master (output addr, wdata, be, we, en, input rdata);
    modport mem    (input addr, wdata, be, we, en, output rdata);
endinterface

// Display side, fixed one-cycle read with valid
interface vga_disp_port_if #(parameter int addr_bits = 15);
    import vga_pkg::*;

    logic [addr_bits-1:0] addr;
    logic                 en;
    logic [word_bits-1:0] data;
    logic                 valid;

    modport fetch (output addr, en, input data, valid);
    modport mem   (input addr, en, output data, valid);
endinterface

`default_nettype wire

// ==== vga/vga_mem.sv ====
// VGA frame-buffer memory
// Byte-organised array with a byte-enabled core port and a display read port
`timescale 1ns/1ps
`default_nettype none

module vga_mem #(
    parameter int h_active = 640,
    parameter int v_active = 480
) (
    input  logic    clock,
    input  logic    rst_n,
    vga_core_port_if.mem core,
    vga_disp_port_if.mem disp
);
    import vga_pkg::*;

    localparam int depth = fb_words(h_active, v_active);
    localparam int addr_bits = fb_addr_bits(h_active, v_active);

    // Behavioural storage with one entry per byte
    logic [7:0] fb_bytes [depth*word_bytes];

    logic core_in_range;

    assign core_in_range = core.addr < depth;

    // Word at a word address or zero outside the frame
    function automatic logic [word_bits-1:0] read_word(logic [addr_bits-1:0] a);
        logic [word_bits-1:0] w;
        w = '0;
        if (a < depth) begin
            for (int b = 0; b < word_bytes; b++) begin
                w[8*b +: 8] = fb_bytes[{a, 2'b00} + b];
            end
        end
        return w;
    endfunction

    // ======================================
    // Core write
    // ======================================
    // Only the lanes picked by be change
    always_ff @(posedge clock) begin
        if (core.en && core.we && core_in_range) begin
            for (int b = 0; b < word_bytes; b++) begin
                if (core.be[b]) begin
                    fb_bytes[{core.addr, 2'b00} + b] <= core.wdata[8*b +: 8];
                end
            end
        end
    end

    // ======================================
    // Registered reads
    // ======================================
    // Same edge as the write so a read sees the old word
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            core.rdata <= '0;
        end else if (core.en) begin
            core.rdata <= read_word(core.addr);
        end
    end

    // Display read with valid one clock behind en
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            disp.valid <= 1'b0;
            disp.data  <= '0;
        end else begin
            disp.valid <= disp.en;
            if (disp.en) begin
                disp.data <= read_word(disp.addr);
            end
        end
    end

endmodule

`default_nettype wire

// ==== vga/vga_timing.sv ====
// VGA raster timing
// Line and frame counters with phase tracking, raw syncs and active flag
`timescale 1ns/1ps
`default_nettype none

module vga_timing #(
    parameter int h_active = 640,
    parameter int v_active = 480,
    localparam int h_bits = vga_pkg::h_count_bits(h_active),
    localparam int v_bits = vga_pkg::v_count_bits(v_active)
) (
    input  logic              clock,
    input  logic              rst_n,
    output logic [h_bits-1:0] h_count,
    output logic [v_bits-1:0] v_count,
    output logic              active,
    output logic              hsync_raw,
    output logic              vsync_raw
);
    import vga_pkg::*;

    localparam int h_total = h_total_of(h_active);
    localparam int v_total = v_total_of(v_active);

    line_phase_e h_phase;
    line_phase_e v_phase;
    logic        h_last;
    logic        v_last;

    // Phase step at the last count of each region
    function automatic line_phase_e next_phase(
        line_phase_e ph,
        int          cnt,
        int          act,
        int          front,
        int          sync,
        int          back
    );
        line_phase_e nxt;
        nxt = ph;
        case (ph)
            ph_active: if (cnt == act - 1) nxt = ph_front;
            ph_front:  if (cnt == act + front - 1) nxt = ph_sync;
            ph_sync:   if (cnt == act + front + sync - 1) nxt = ph_back;
            ph_back:   if (cnt == act + front + sync + back - 1) nxt = ph_active;
            default:   nxt = ph_active;
        endcase
        return nxt;
    endfunction

    assign h_last = h_count == h_bits'(h_total - 1);
    assign v_last = v_count == v_bits'(v_total - 1);

    // ======================================
    // Horizontal counter, every clock
    // ======================================
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            h_count <= '0;
            h_phase <= ph_active;
        end else begin
            h_count <= h_last ? '0 : h_count + 1'b1;
            h_phase <= next_phase(h_phase, int'(h_count), h_active, h_front, h_sync, h_back);
        end
    end

    // ======================================
    // Vertical counter, once per line wrap
    // ======================================
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            v_count <= '0;
            v_phase <= ph_active;
        end else if (h_last) begin
            v_count <= v_last ? '0 : v_count + 1'b1;
            v_phase <= next_phase(v_phase, int'(v_count), v_active, v_front, v_sync, v_back);
        end
    end

    // Decoded straight from the phase registers
    assign active    = (h_phase == ph_active) && (v_phase == ph_active);
    assign hsync_raw = (h_phase == ph_sync) ? sync_active : ~sync_active;
    assign vsync_raw = (v_phase == ph_sync) ? sync_active : ~sync_active;

endmodule

`default_nettype wire

// ==== vga/vga_pixel_fetch.sv ====
// VGA pixel fetch and serialiser
// Reads frame words ahead of the beam and shifts them out LSB first
`timescale 1ns/1ps
`default_nettype none

module vga_pixel_fetch #(
    parameter int h_active = 640,
    parameter int v_active = 480,
    localparam int h_bits = vga_pkg::h_count_bits(h_active),
    localparam int v_bits = vga_pkg::v_count_bits(v_active)
) (
    input  logic              clock,
    input  logic              rst_n,
    input  logic [h_bits-1:0] h_count,
    input  logic [v_bits-1:0] v_count,
    input  logic              active,
    input  logic              hsync_raw,
    input  logic              vsync_raw,
    vga_disp_port_if.fetch    rd,
    output logic              hsync,
    output logic              vsync,
    output logic              video_on,
    output logic              pixel
);
    import vga_pkg::*;

    localparam int words_per_line = h_active / word_bits;
    localparam int h_total = h_total_of(h_active);
    localparam int v_total = v_total_of(v_active);
    localparam int addr_bits = fb_addr_bits(h_active, v_active);

    logic [pix_sel_bits-1:0]        bit_pos;
    logic [v_bits-1:0]              next_line;
    logic [v_bits-1:0]              req_line;
    logic [h_bits-pix_sel_bits-1:0] req_word;
    logic                           inline_req;
    logic                           prefetch_req;
    logic [word_bits-1:0]           staged;
    logic [word_bits-1:0]           shreg;
    logic                           pix_bit;

    assign bit_pos   = h_count[pix_sel_bits-1:0];
    assign next_line = (v_count == v_bits'(v_total - 1)) ? '0 : v_count + 1'b1;

    // ======================================
    // Read requests, two clocks ahead
    // ======================================
    // Next word of this line, skipped after the last word
    assign inline_req = active && (bit_pos == pix_sel_bits'(word_bits - 2))
                        && (int'(h_count) + 2 < h_active);
    // Word 0 of the coming line
    assign prefetch_req = (h_count == h_bits'(h_total - 2)) && (next_line < v_active);

    assign req_line = inline_req ? v_count : next_line;
    assign req_word = inline_req ? h_count[h_bits-1:pix_sel_bits] + 1'b1 : '0;
    assign rd.en    = inline_req || prefetch_req;
    assign rd.addr  = addr_bits'(req_line * words_per_line + req_word);

    // Returned word waits here until its boundary
    always_ff @(posedge clock) begin
        if (rd.valid) begin
            staged <= rd.data;
        end
    end

    // Loaded at bit 0 with the rest of the word
    always_ff @(posedge clock) begin
        if (bit_pos == '0) begin
            shreg <= staged >> 1;
        end else begin
            shreg <= shreg >> 1;
        end
    end

    // Bit 0 comes straight from the staging register
    assign pix_bit = (bit_pos == '0) ? staged[0] : shreg[0];

    // All four outputs one clock behind the counters
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            pixel    <= 1'b0;
            video_on <= 1'b0;
            hsync    <= ~sync_active;
            vsync    <= ~sync_active;
        end else begin
            pixel    <= active ? pix_bit : 1'b0;
            video_on <= active;
            hsync    <= hsync_raw;
            vsync    <= vsync_raw;
        end
    end

endmodule

`default_nettype wire

// ==== source/vga_wb_slave.sv ====
// Wishbone classic slave for the frame buffer
// One access in flight, ack one clock after the request
`timescale 1ns/1ps
`default_nettype none

module vga_wb_slave #(
    parameter int addr_bits = 15
) (
    input  logic                           clock,
    input  logic                           rst_n,
    input  logic                           wb_cyc,
    input  logic                           wb_stb,
    input  logic                           wb_we,
    input  logic [addr_bits-1:0]           wb_adr,
    input  logic [vga_pkg::word_bits-1:0]  wb_dat_w,
    input  logic [vga_pkg::word_bytes-1:0] wb_sel,
    output logic [vga_pkg::word_bits-1:0]  wb_dat_r,
    output logic                           wb_ack,
    vga_core_port_if.master                port
);

    logic new_req;

    // ======================================
    // Request decode
    // ======================================
    // Master holds stb through the ack cycle
    // so the ack itself masks the second look
    assign new_req = wb_cyc && wb_stb && !wb_ack;

    // Memory strobe, one clock per access
    assign port.en = new_req;

    // Bus fields go straight through
    assign port.we    = wb_we;
    assign port.be    = wb_sel;
    assign port.addr  = wb_adr;
    assign port.wdata = wb_dat_w;

    // ======================================
    // Acknowledge
    // ======================================
    // Single-cycle pulse, fixed latency of one
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            wb_ack <= 1'b0;
        end else begin
            wb_ack <= new_req;
        end
    end

    // Memory read register lines up with the ack
    assign wb_dat_r = port.rdata;

endmodule

`default_nettype wire

// ==== source/vga_subsys_top.sv ====
// Monochrome VGA frame-buffer subsystem
// Wishbone slave, frame memory, raster timing and pixel fetch
`timescale 1ns/1ps
`default_nettype none

module vga_subsys_top #(
    parameter int h_active = 640,
    parameter int v_active = 480,
    localparam int addr_bits = vga_pkg::fb_addr_bits(h_active, v_active)
) (
    input  logic                           clock,
    input  logic                           rst_n,
    // Wishbone classic
    input  logic                           wb_cyc,
    input  logic                           wb_stb,
    input  logic                           wb_we,
    input  logic [addr_bits-1:0]           wb_adr,
    input  logic [vga_pkg::word_bits-1:0]  wb_dat_w,
    input  logic [vga_pkg::word_bytes-1:0] wb_sel,
    output logic [vga_pkg::word_bits-1:0]  wb_dat_r,
    output logic                           wb_ack,
    // Display
    output logic                           hsync,
    output logic                           vsync,
    output logic                           video_on,
    output logic                           pixel
);
    import vga_pkg::*;

    localparam int h_bits = h_count_bits(h_active);
    localparam int v_bits = v_count_bits(v_active);

    // ======================================
    // Internal buses
    // ======================================
    vga_core_port_if #(.addr_bits(addr_bits)) core_port ();
    vga_disp_port_if #(.addr_bits(addr_bits)) disp_port ();

    // Raster position and raw timing
    logic [h_bits-1:0] h_count;
    logic [v_bits-1:0] v_count;
    logic              active;
    logic              hsync_raw;
    logic              vsync_raw;

    vga_wb_slave #(.addr_bits(addr_bits)) u_wb_slave (
        .clock(clock), .rst_n(rst_n),
        .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
        .wb_dat_w(wb_dat_w), .wb_sel(wb_sel), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack),
        .port(core_port.master)
    );

    vga_mem #(.h_active(h_active), .v_active(v_active)) u_mem (
        .clock(clock), .rst_n(rst_n), .core(core_port.mem), .disp(disp_port.mem)
    );

    vga_timing #(.h_active(h_active), .v_active(v_active)) u_timing (
        .clock(clock), .rst_n(rst_n), .h_count(h_count), .v_count(v_count),
        .active(active), .hsync_raw(hsync_raw), .vsync_raw(vsync_raw)
    );

    vga_pixel_fetch #(.h_active(h_active), .v_active(v_active)) u_fetch (
        .clock(clock), .rst_n(rst_n), .h_count(h_count), .v_count(v_count),
        .active(active), .hsync_raw(hsync_raw), .vsync_raw(vsync_raw),
        .rd(disp_port.fetch),
        .hsync(hsync), .vsync(vsync), .video_on(video_on), .pixel(pixel)
    );

endmodule

`default_nettype wire

// ==== tb/vga_subsys_props.sv ====
// Bound checks for the VGA frame-buffer subsystem
// Wishbone ack handshake and blanking during sync
`timescale 1ns/1ps
`default_nettype none

module vga_subsys_props (
    input logic clock,
    input logic rst_n,
    input logic wb_cyc,
    input logic wb_stb,
    input logic wb_ack,
    input logic hsync,
    input logic vsync,
    input logic video_on
);
    import vga_pkg::*;

    // Ack only answers a live request
    ack_after_request: assert property (@(posedge clock) disable iff (!rst_n)
        wb_ack |-> $past(wb_cyc && wb_stb))
        else $error("wb_ack raised without a request in the cycle before");

    // Single-cycle ack pulse
    ack_one_cycle: assert property (@(posedge clock) disable iff (!rst_n)
        wb_ack |=> !wb_ack)
        else $error("wb_ack high for two cycles running");

    // No video inside either sync pulse
    blank_in_sync: assert property (@(posedge clock) disable iff (!rst_n)
        (hsync == sync_active || vsync == sync_active) |-> !video_on)
        else $error("video_on high during a sync pulse");

endmodule

bind vga_subsys_top vga_subsys_props u_props (
    .clock(clock), .rst_n(rst_n), .wb_cyc(wb_cyc), .wb_stb(wb_stb),
    .wb_ack(wb_ack), .hsync(hsync), .vsync(vsync), .video_on(video_on)
);

`default_nettype wire

// ==== tb/vga_subsys_tb.sv ====
// VGA frame-buffer subsystem testbench
// Wishbone traffic against a reference frame, then raster and pixel checks
`timescale 1ns/1ps
`default_nettype none

module vga_subsys_tb;
    import vga_pkg::*;

    // ========================================
    // Geometry of the small test frame
    // ========================================
    localparam int h_act = 64;
    localparam int v_act = 8;
    localparam int words_per_line = h_act / 32;
    localparam int depth = words_per_line * v_act;
    localparam int adr_bits = $clog2(depth) + 1;
    localparam int hsync_clocks = 96;
    localparam int frame_cycles = (h_act + 16 + 96 + 48) * (v_act + 10 + 2 + 33);
    // Roughly 120 bus accesses of 3 clocks each
    localparam int bus_cycles = 120 * 3;
    localparam int timeout_ns = (3 * frame_cycles + bus_cycles + frame_cycles / 2) * 40;

    logic clock = 1'b0;
    logic rst_n;
    logic wb_cyc, wb_stb, wb_we, wb_ack;
    logic [adr_bits-1:0] wb_adr;
    logic [31:0] wb_dat_w, wb_dat_r;
    logic [3:0] wb_sel;
    logic hsync, vsync, video_on, pixel;

    logic [31:0] ref_frame [depth];
    logic [31:0] exp_rdata = '0;
    logic exp_is_read = 1'b0;
    logic exp_pix;
    // Raster bookkeeping of the compare process
    logic check_en = 1'b0;
    logic frame_check = 1'b0;
    logic prev_video_on = 1'b0;
    logic prev_hsync = 1'b1;
    logic prev_vsync = 1'b1;
    int x_pos = 0;
    int y_pos = 0;
    int hsync_len = 0;
    int frames_checked = 0;
    int error_count = 0;
    int seed_dummy;

    vga_subsys_top #(.h_active(h_act), .v_active(v_act)) DUT (
        .clock(clock), .rst_n(rst_n),
        .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
        .wb_dat_w(wb_dat_w), .wb_sel(wb_sel), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack),
        .hsync(hsync), .vsync(vsync), .video_on(video_on), .pixel(pixel)
    );

    initial begin
        forever #20 clock = ~clock;
    end

    // Reference model: byte lanes picked by sel take the new data
    function automatic logic [31:0] merge_bytes(logic [31:0] old_word,
                                                logic [31:0] new_word, logic [3:0] sel);
        logic [31:0] res;
        res = old_word;
        for (int b = 0; b < 4; b++) begin
            if (sel[b]) res[8*b +: 8] = new_word[8*b +: 8];
        end
        return res;
    endfunction

    // Out-of-range addresses read as zero
    function automatic logic [31:0] expected_word(logic [adr_bits-1:0] adr);
        return (adr < depth) ? ref_frame[adr] : 32'h0;
    endfunction

    task automatic fail_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        $display("FAILED %s got 0x%08h expected 0x%08h", name, got, exp);
        error_count++;
        $display("SOME TESTS FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic fail_plain(input string what);
        $display("%s", what);
        error_count++;
        $display("SOME TESTS FAILED");
        $fatal(1, "stopped at first error");
    endtask

    // One Wishbone classic access, driven on the falling edge
    task automatic bus_access(input logic we, input logic [adr_bits-1:0] adr,
                              input logic [31:0] data, input logic [3:0] sel);
        int waited;
        @(negedge clock);
        exp_is_read = !we;
        exp_rdata = expected_word(adr);
        wb_cyc = 1'b1;
        wb_stb = 1'b1;
        wb_we = we;
        wb_adr = adr;
        wb_dat_w = data;
        wb_sel = sel;
        waited = 0;
        do begin
            @(negedge clock);
            waited++;
        end while (!wb_ack && waited < 8);
        assert (wb_ack) else fail_plain("wb_ack never came within 8 clocks");
        assert (waited == 1) else fail_value("wb_ack latency", waited, 1);
        if (we && adr < depth) ref_frame[adr] = merge_bytes(ref_frame[adr], data, sel);
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we = 1'b0;
    endtask

    // ========================================
    // Compare process, sampled at the rising edge
    // ========================================
    always @(posedge clock) begin
        if (rst_n) begin
            // Read data arrives with the ack
            if (wb_ack && exp_is_read) begin
                assert (wb_dat_r == exp_rdata) else fail_value("wb_dat_r", wb_dat_r, exp_rdata);
            end
            if (video_on) begin
                if (frame_check) begin
                    assert (x_pos < h_act && y_pos < v_act)
                        else fail_plain("video_on high outside the 64x8 active area");
                    exp_pix = ref_frame[y_pos * words_per_line + x_pos / 32][x_pos % 32];
                    assert (pixel == exp_pix) else fail_value("pixel", pixel, exp_pix);
                end
                x_pos++;
            end else if (prev_video_on) begin
                if (frame_check) begin
                    assert (x_pos == h_act) else fail_value("pixels per line", x_pos, h_act);
                end
                x_pos = 0;
                y_pos++;
            end
            // Sync pulse width
            if (!hsync) begin
                hsync_len++;
            end else if (!prev_hsync) begin
                assert (hsync_len == hsync_clocks)
                    else fail_value("hsync width", hsync_len, hsync_clocks);
                hsync_len = 0;
            end
            // Frame boundary at the start of the vsync pulse
            if (!vsync && prev_vsync) begin
                if (frame_check) begin
                    assert (y_pos == v_act) else fail_value("lines per frame", y_pos, v_act);
                    frames_checked++;
                end
                frame_check = check_en;
                y_pos = 0;
            end
            prev_video_on = video_on;
            prev_hsync = hsync;
            prev_vsync = vsync;
        end
    end

    initial begin
        #(timeout_ns);
        $display("Watchdog expired before all frames were checked");
        $display("SOME TESTS FAILED");
        $fatal(1, "timeout");
    end

    // ========================================
    // Stimulus
    // ========================================
    initial begin
        seed_dummy = $urandom(32'ha72dd7e2);
        rst_n = 1'b0;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we = 1'b0;
        wb_adr = '0;
        wb_dat_w = '0;
        wb_sel = '0;
        repeat (2) @(posedge clock);
        @(negedge clock);
        // Reset values before the first counted clock
        assert (!wb_ack && !video_on && !pixel && hsync && vsync)
            else fail_plain("outputs not at their reset values");
        rst_n = 1'b1;

        // Full words everywhere, then read back
        for (int a = 0; a < depth; a++) bus_access(1'b1, a, $urandom, 4'hf);
        for (int a = 0; a < depth; a++) bus_access(1'b0, a, 32'h0, 4'h0);
        // Byte-enabled writes
        for (int i = 0; i < 24; i++) begin
            wb_adr = $urandom_range(depth - 1, 0);
            bus_access(1'b1, wb_adr, $urandom, $urandom);
            bus_access(1'b0, wb_adr, 32'h0, 4'h0);
        end
        // Past the end of the frame
        bus_access(1'b1, depth, 32'hdead_beef, 4'hf);
        bus_access(1'b1, 2 * depth - 1, 32'h1234_5678, 4'hf);
        bus_access(1'b0, depth, 32'h0, 4'h0);
        bus_access(1'b0, 2 * depth - 1, 32'h0, 4'h0);
        for (int a = 0; a < depth; a++) bus_access(1'b0, a, 32'h0, 4'h0);

        // Check the next full frame
        check_en = 1'b1;
        while (!frame_check) @(negedge clock);
        check_en = 1'b0;
        while (frames_checked < 1) @(negedge clock);

        // Rewrite an already shown word halfway down the frame
        while (y_pos < v_act / 2) @(negedge clock);
        bus_access(1'b1, words_per_line, ~ref_frame[words_per_line], 4'hf);
        check_en = 1'b1;
        while (!frame_check) @(negedge clock);
        check_en = 1'b0;
        while (frames_checked < 2) @(negedge clock);

        if (error_count == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== all.f ====
common/vga_pkg.sv
common/vga_mem_ifs.sv
vga/vga_mem.sv
vga/vga_timing.sv
vga/vga_pixel_fetch.sv
source/vga_wb_slave.sv
source/vga_subsys_top.sv
tb/vga_subsys_props.sv
tb/vga_subsys_tb.sv

// ==== Bender.yml ====
package:
  name: vga_subsys

sources:
  # Shared package and interfaces
  - common/vga_pkg.sv
  - common/vga_mem_ifs.sv
  # Display blocks
  - vga/vga_mem.sv
  - vga/vga_timing.sv
  - vga/vga_pixel_fetch.sv
  # Bus slave and top level
  - source/vga_wb_slave.sv
  - source/vga_subsys_top.sv
  # Testbench
  - target: test
    files:
      - tb/vga_subsys_props.sv
      - tb/vga_subsys_tb.sv
